// File: hw/dpPkg.sv
package dpPkg;

	// datapath word width, the top level passes it down as a parameter
	localparam int dataWidth = 16;

	// register bank geometry
	localparam int regCount = 8;
	localparam int regNumWidth = $clog2(regCount);

	// word memory depth is 2**memAddrWidth
	localparam int memAddrWidth = 8;

	// constant source on bus1, used for the pc increment
	localparam int pcStep = 2;

	// bus1 source select
	localparam logic [2:0] bus1Pc = 3'd0;
	localparam logic [2:0] bus1Const = 3'd1;
	localparam logic [2:0] bus1Reg = 3'd2;
	localparam logic [2:0] bus1Mdr = 3'd3;
	localparam logic [2:0] bus1AluOut = 3'd4;

	// alu opcodes, 6 and 7 are unused
	localparam logic [2:0] opAdd = 3'd0;
	localparam logic [2:0] opSub = 3'd1;
	localparam logic [2:0] opOr = 3'd2;
	localparam logic [2:0] opAnd = 3'd3;
	localparam logic [2:0] opCmp = 3'd4;
	localparam logic [2:0] opMns = 3'd5;

	// where the register bank takes its register number from
	localparam logic [1:0] regNumExt = 2'd0;
	localparam logic [1:0] regNumA = 2'd1;
	localparam logic [1:0] regNumB = 2'd2;
	localparam logic [1:0] regNumC = 2'd3;

	// bit positions in the flags vector, jumpSel uses the same numbering
	localparam int flagMinus = 3;
	localparam int flagZero = 2;
	localparam int flagOverflow = 1;
	localparam int flagCarry = 0;

	// instruction word, seen as register fields or as a jump with a sense bit
	typedef union packed {
		struct packed {
			logic [2:0] regA;
			logic [2:0] regB;
			logic [2:0] midBits;
			logic [2:0] regC;
			logic [3:0] lowBits;
		} regForm;
		struct packed {
			logic [7:0] highBits;
			logic       sense;
			logic [6:0] lowBits;
		} jumpForm;
	} instrWordT;

endpackage

// File: hw/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import dpPkg::*; #(
	parameter int dataWidth = dpPkg::dataWidth
) (
	input  logic [2:0]           aluOp,
	input  logic [dataWidth-1:0] opA,
	input  logic [dataWidth-1:0] opB,
	output logic [dataWidth-1:0] result,
	output logic                 carryOut,
	output logic                 carryIntoTop
);

	logic [dataWidth-1:0] addA;
	logic [dataWidth-1:0] addB;
	logic                 addCin;
	logic                 useAdder;
	logic [dataWidth-1:0] logicRes;
	logic [dataWidth-1:0] lowSum;
	logic [1:0]           topSum;

	// operand setup, subtraction is a + ~b + 1
	always_comb begin
		addA = opA;
		addB = opB;
		addCin = 1'b0;
		useAdder = 1'b1;
		logicRes = '0;
		case (aluOp)
			opAdd: addCin = 1'b0;
			// cmp computes the same difference, it is only there for the flags
			opSub, opCmp: begin
				addB = ~opB;
				addCin = 1'b1;
			end
			opMns: begin
				addA = '0;
				addB = ~opB;
				addCin = 1'b1;
			end
			opOr: begin
				useAdder = 1'b0;
				logicRes = opA | opB;
			end
			opAnd: begin
				useAdder = 1'b0;
				logicRes = opA & opB;
			end
			default: useAdder = 1'b0;
		endcase
	end

	// low bits first, so the carry into the sign bit is visible
	assign lowSum = {1'b0, addA[dataWidth-2:0]} + {1'b0, addB[dataWidth-2:0]}
		+ {{(dataWidth-1){1'b0}}, addCin};
	assign topSum = {1'b0, addA[dataWidth-1]} + {1'b0, addB[dataWidth-1]}
		+ {1'b0, lowSum[dataWidth-1]};

	// logic ops report no carries
	assign result = useAdder ? {topSum[0], lowSum[dataWidth-2:0]} : logicRes;
	assign carryOut = useAdder & topSum[1];
	assign carryIntoTop = useAdder & lowSum[dataWidth-1];

endmodule

// File: hw/regBank.sv
`timescale 1ns/1ps

module regBank import dpPkg::*; #(
	parameter int dataWidth = dpPkg::dataWidth
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [1:0]             regNumSrc,
	input  logic [regNumWidth-1:0] regNum,
	input  instrWordT              irValue,
	input  logic                   regWrite,
	input  logic                   regWdSrc,
	input  logic [dataWidth-1:0]   bus1,
	input  logic [dataWidth-1:0]   bus2,
	output logic [dataWidth-1:0]   readData
);

	logic [dataWidth-1:0]   regs [regCount];
	logic [regNumWidth-1:0] regSel;
	logic [dataWidth-1:0]   writeData;

	// register number from outside or from one of the IR fields
	always_comb begin
		case (regNumSrc)
			regNumA: regSel = irValue.regForm.regA;
			regNumB: regSel = irValue.regForm.regB;
			regNumC: regSel = irValue.regForm.regC;
			default: regSel = regNum;
		endcase
	end

	// 0 takes bus1, 1 takes the alu result
	assign writeData = regWdSrc ? bus2 : bus1;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite) begin
			regs[regSel] <= writeData;
		end
	end

	// read port feeds the bus1 mux, same register as the write
	assign readData = regs[regSel];

	// an X number here would corrupt an unknown register
	regSelKnown: assert property (@(posedge clk) disable iff (!rstN)
		regWrite |-> !$isunknown(regSel));

endmodule

// File: hw/statusFlags.sv
`timescale 1ns/1ps

module statusFlags import dpPkg::*; #(
	parameter int dataWidth = dpPkg::dataWidth
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 flagWrite,
	input  logic [dataWidth-1:0] result,
	input  logic                 carryOut,
	input  logic                 carryIntoTop,
	input  logic                 jumpEn,
	input  logic [1:0]           jumpSel,
	input  instrWordT            irValue,
	output logic [3:0]           flags,
	output logic                 jumpTaken
);

	logic [3:0] flagsNext;
	logic       selFlag;

	// candidate flags straight from the alu outputs
	always_comb begin
		flagsNext = '0;
		flagsNext[flagMinus] = result[dataWidth-1];
		flagsNext[flagZero] = ~|result;
		// signed overflow when the carries into and out of the sign bit differ
		flagsNext[flagOverflow] = carryIntoTop ^ carryOut;
		flagsNext[flagCarry] = carryOut;
	end

	// all four flags load together
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (flagWrite) begin
			flags <= flagsNext;
		end
	end

	// jumpSel uses the flag bit numbering directly
	assign selFlag = flags[jumpSel];

	// jump when the stored flag equals the sense bit of IR
	assign jumpTaken = jumpEn & (selFlag ~^ irValue.jumpForm.sense);

endmodule

// File: hw/memBank.sv
`timescale 1ns/1ps

module memBank import dpPkg::*; #(
	parameter int dataWidth = dpPkg::dataWidth,
	parameter int memAddrWidth = dpPkg::memAddrWidth
) (
	input  logic                    clk,
	input  logic                    memWrite,
	input  logic [memAddrWidth-1:0] addr,
	input  logic [dataWidth-1:0]    writeData,
	output logic [dataWidth-1:0]    readData
);

	// one word per address
	logic [dataWidth-1:0] mem [2**memAddrWidth];

	// write from MDR at the edge
	always_ff @(posedge clk) begin
		if (memWrite) begin
			mem[addr] <= writeData;
		end
	end

	// asynchronous read, MDR picks it up through its source mux
	assign readData = mem[addr];

	// MAR must hold a real address before a write
	memAddrKnown: assert property (@(posedge clk)
		memWrite |-> !$isunknown(addr));

endmodule

// File: hw/specialRegs.sv
`timescale 1ns/1ps

module specialRegs import dpPkg::*; #(
	parameter int dataWidth = dpPkg::dataWidth
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic [dataWidth-1:0] bus1,
	input  logic [dataWidth-1:0] bus2,
	input  logic [dataWidth-1:0] memData,
	input  logic                 jumpTaken,
	input  logic                 pcWrite,
	input  logic                 marWrite,
	input  logic                 marSrc,
	input  logic                 mdrWrite,
	input  logic                 mdrSrc,
	input  logic                 irWrite,
	input  logic                 tWrite,
	input  logic                 aluOutWrite,
	output logic [dataWidth-1:0] pcValue,
	output logic [dataWidth-1:0] marValue,
	output logic [dataWidth-1:0] mdrValue,
	output instrWordT            irValue,
	output logic [dataWidth-1:0] tValue,
	output logic [dataWidth-1:0] aluOutValue
);

	logic                 pcLoad;
	logic [dataWidth-1:0] marNext;
	logic [dataWidth-1:0] mdrNext;

	// pc takes bus2 on an explicit write or on a taken jump
	assign pcLoad = pcWrite | jumpTaken;

	// MAR: 0 is bus1, 1 is bus2
	assign marNext = marSrc ? bus2 : bus1;

	// MDR: 0 is bus2, 1 is the memory read word
	assign mdrNext = mdrSrc ? memData : bus2;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcValue <= '0;
			marValue <= '0;
			mdrValue <= '0;
			irValue <= '0;
			tValue <= '0;
			aluOutValue <= '0;
		end else begin
			if (pcLoad) begin
				pcValue <= bus2;
			end
			if (marWrite) begin
				marValue <= marNext;
			end
			if (mdrWrite) begin
				mdrValue <= mdrNext;
			end
			// IR and T both load from bus1
			if (irWrite) begin
				irValue <= bus1;
			end
			if (tWrite) begin
				tValue <= bus1;
			end
			if (aluOutWrite) begin
				aluOutValue <= bus2;
			end
		end
	end

	// the alu result must be settled whenever pc takes it, jump loads included
	pcSrcKnown: assert property (@(posedge clk) disable iff (!rstN)
		pcLoad |-> !$isunknown(bus2));

endmodule

// File: hw/datapathTop.sv
`timescale 1ns/1ps

module datapathTop import dpPkg::*; #(
	parameter int dataWidth = dpPkg::dataWidth,
	parameter int memAddrWidth = dpPkg::memAddrWidth
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [2:0]             bus1Sel,
	input  logic [2:0]             aluOp,
	input  logic [1:0]             regNumSrc,
	input  logic [regNumWidth-1:0] regNum,
	input  logic                   regWrite,
	input  logic                   regWdSrc,
	input  logic                   tWrite,
	input  logic                   irWrite,
	input  logic                   pcWrite,
	input  logic                   aluOutWrite,
	input  logic                   marWrite,
	input  logic                   marSrc,
	input  logic                   mdrWrite,
	input  logic                   mdrSrc,
	input  logic                   memWrite,
	input  logic                   flagWrite,
	input  logic                   jumpEn,
	input  logic [1:0]             jumpSel,
	output logic [dataWidth-1:0]   pcValue,
	output logic [dataWidth-1:0]   bus1,
	output logic [dataWidth-1:0]   bus2,
	output logic [3:0]             flags
);

	logic [dataWidth-1:0] regReadData;
	logic [dataWidth-1:0] marValue;
	logic [dataWidth-1:0] mdrValue;
	logic [dataWidth-1:0] tValue;
	logic [dataWidth-1:0] aluOutValue;
	logic [dataWidth-1:0] memReadData;
	logic [memAddrWidth-1:0] memAddr;
	instrWordT            irValue;
	logic                 carryOut;
	logic                 carryIntoTop;
	logic                 jumpTaken;
	logic                 aluUsed;

	// bus1 source mux over the five sources
	always_comb begin
		case (bus1Sel)
			bus1Pc:     bus1 = pcValue;
			bus1Const:  bus1 = dataWidth'(pcStep);
			bus1Reg:    bus1 = regReadData;
			bus1Mdr:    bus1 = mdrValue;
			bus1AluOut: bus1 = aluOutValue;
			default:    bus1 = '0;
		endcase
	end

	// memory is word addressed by the low bits of MAR
	assign memAddr = marValue[memAddrWidth-1:0];

	regBank #(.dataWidth(dataWidth)) uRegBank (
		.clk(clk), .rstN(rstN), .regNumSrc(regNumSrc), .regNum(regNum),
		.irValue(irValue), .regWrite(regWrite), .regWdSrc(regWdSrc),
		.bus1(bus1), .bus2(bus2), .readData(regReadData)
	);

	// bus2 is always the alu result of T on the left and bus1 on the right
	aluUnit #(.dataWidth(dataWidth)) uAlu (
		.aluOp(aluOp), .opA(tValue), .opB(bus1),
		.result(bus2), .carryOut(carryOut), .carryIntoTop(carryIntoTop)
	);

	statusFlags #(.dataWidth(dataWidth)) uFlags (
		.clk(clk), .rstN(rstN), .flagWrite(flagWrite), .result(bus2),
		.carryOut(carryOut), .carryIntoTop(carryIntoTop), .jumpEn(jumpEn),
		.jumpSel(jumpSel), .irValue(irValue), .flags(flags), .jumpTaken(jumpTaken)
	);

	memBank #(.dataWidth(dataWidth), .memAddrWidth(memAddrWidth)) uMem (
		.clk(clk), .memWrite(memWrite), .addr(memAddr),
		.writeData(mdrValue), .readData(memReadData)
	);

	specialRegs #(.dataWidth(dataWidth)) uSpecial (
		.clk(clk), .rstN(rstN), .bus1(bus1), .bus2(bus2), .memData(memReadData),
		.jumpTaken(jumpTaken), .pcWrite(pcWrite), .marWrite(marWrite),
		.marSrc(marSrc), .mdrWrite(mdrWrite), .mdrSrc(mdrSrc), .irWrite(irWrite),
		.tWrite(tWrite), .aluOutWrite(aluOutWrite), .pcValue(pcValue),
		.marValue(marValue), .mdrValue(mdrValue), .irValue(irValue),
		.tValue(tValue), .aluOutValue(aluOutValue)
	);

	// any strobe that samples bus2 or the alu carries this edge
	assign aluUsed = pcWrite || jumpTaken || aluOutWrite || flagWrite ||
		(regWrite && regWdSrc) || (marWrite && marSrc) || (mdrWrite && !mdrSrc);

	// the two spare opcodes must never reach a register
	aluOpLegal: assert property (@(posedge clk) disable iff (!rstN)
		aluUsed |-> aluOp <= opMns);

endmodule

// File: bench/dpChecker.sv
`timescale 1ns/1ps

module dpChecker (
	input logic        clk,
	input logic [15:0] pcValue,
	input logic [15:0] bus1,
	input logic [15:0] bus2,
	input logic [3:0]  flags,
	input logic        chkPc,
	input logic        chkBus1,
	input logic        chkBus2,
	input logic        chkFlags,
	input logic [15:0] expPc,
	input logic [15:0] expBus1,
	input logic [15:0] expBus2,
	input logic [3:0]  expFlags
);

	int errCount = 0;
	int markErr = 0;
	int testsRun = 0;
	int testsBad = 0;

	// one ERR line per wrong value
	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			errCount++;
		end
	endtask

	// inputs change on the rising edge, so the falling edge sees settled values
	always @(negedge clk) begin
		if (chkPc) begin
			compare("pcValue", pcValue, expPc);
		end
		if (chkBus1) begin
			compare("bus1", bus1, expBus1);
		end
		if (chkBus2) begin
			compare("bus2", bus2, expBus2);
		end
		if (chkFlags) begin
			compare("flags", {12'd0, flags}, {12'd0, expFlags});
		end
	end

	// mismatches since the previous call belong to this test
	task automatic endTest(input string name);
		testsRun++;
		if (errCount == markErr) begin
			$display("test %s: ok", name);
		end else begin
			testsBad++;
			$display("test %s: %0d mismatches", name, errCount - markErr);
		end
		markErr = errCount;
	endtask

	task automatic summary();
		$display("tests run %0d, bad %0d, mismatches %0d", testsRun, testsBad, errCount);
	endtask

endmodule

// File: bench/tbDatapath.sv
`timescale 1ns/1ps

module tbDatapath import dpPkg::*; ();

	localparam int maxCycles = 50000;

	logic clk = 1'b0;
	logic rstN;
	logic [2:0] bus1Sel, aluOp, regNum;
	logic [1:0] regNumSrc, jumpSel;
	logic regWrite, regWdSrc, tWrite, irWrite, pcWrite, aluOutWrite;
	logic marWrite, marSrc, mdrWrite, mdrSrc, memWrite, flagWrite, jumpEn;
	logic [15:0] pcValue, bus1, bus2;
	logic [3:0] flags;
	logic chkPc, chkBus1, chkBus2, chkFlags;
	logic [15:0] expPc, expBus1, expBus2;
	logic [3:0] expFlags;

	// reference model state
	logic [15:0] mRegs [8];
	logic [15:0] mPc, mT;
	logic [3:0] mFlags;
	logic [15:0] mMem [logic [15:0]];
	logic [15:0] addrQ [$];
	int seed = 52901;
	logic done = 1'b0;

	always #2 clk = ~clk;

	datapathTop datapathTop_inst (
		.clk(clk), .rstN(rstN), .bus1Sel(bus1Sel), .aluOp(aluOp), .regNumSrc(regNumSrc),
		.regNum(regNum), .regWrite(regWrite), .regWdSrc(regWdSrc), .tWrite(tWrite),
		.irWrite(irWrite), .pcWrite(pcWrite), .aluOutWrite(aluOutWrite),
		.marWrite(marWrite), .marSrc(marSrc), .mdrWrite(mdrWrite), .mdrSrc(mdrSrc),
		.memWrite(memWrite), .flagWrite(flagWrite), .jumpEn(jumpEn), .jumpSel(jumpSel),
		.pcValue(pcValue), .bus1(bus1), .bus2(bus2), .flags(flags)
	);

	dpChecker chk (
		.clk(clk), .pcValue(pcValue), .bus1(bus1), .bus2(bus2), .flags(flags),
		.chkPc(chkPc), .chkBus1(chkBus1), .chkBus2(chkBus2), .chkFlags(chkFlags),
		.expPc(expPc), .expBus1(expBus1), .expBus2(expBus2), .expFlags(expFlags)
	);

	function automatic logic [15:0] rnd16();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// carry is no-borrow for subtraction and overflow comes from the operand signs
	task automatic aluRef(input logic [2:0] op, input logic [15:0] a, input logic [15:0] b,
		output logic [15:0] r, output logic [3:0] f);
		logic [16:0] wide;
		logic c;
		logic v;
		c = 1'b0;
		v = 1'b0;
		r = 16'd0;
		case (op)
			opAdd: begin
				wide = a + b;
				r = wide[15:0];
				c = wide[16];
				v = (a[15] == b[15]) && (r[15] != a[15]);
			end
			opSub, opCmp: begin
				r = a - b;
				c = (a >= b);
				v = (a[15] != b[15]) && (r[15] != a[15]);
			end
			opMns: begin
				r = -b;
				c = (b == 16'd0);
				v = (b == 16'h8000);
			end
			opOr: r = a | b;
			opAnd: r = a & b;
			default: r = 16'd0;
		endcase
		f = {r[15], r == 16'd0, v, c};
	endtask

	// wait for the next rising edge and drop strobes and checks unless set again
	task automatic tick();
		@(posedge clk);
		regWrite <= 1'b0;
		tWrite <= 1'b0;
		irWrite <= 1'b0;
		pcWrite <= 1'b0;
		aluOutWrite <= 1'b0;
		marWrite <= 1'b0;
		mdrWrite <= 1'b0;
		memWrite <= 1'b0;
		flagWrite <= 1'b0;
		jumpEn <= 1'b0;
		chkPc <= 1'b0;
		chkBus1 <= 1'b0;
		chkBus2 <= 1'b0;
		chkFlags <= 1'b0;
	endtask

	task automatic expectBus1(input logic [15:0] v);
		chkBus1 <= 1'b1;
		expBus1 <= v;
	endtask

	task automatic expectBus2(input logic [15:0] v);
		chkBus2 <= 1'b1;
		expBus2 <= v;
	endtask

	task automatic expectPc(input logic [15:0] v);
		chkPc <= 1'b1;
		expPc <= v;
	endtask

	task automatic loadTReg(input logic [2:0] idx);
		tick();
		bus1Sel <= bus1Reg;
		regNum <= idx;
		tWrite <= 1'b1;
		mT = mRegs[idx];
	endtask

	// T op bus1 written back into the same register through bus2
	task automatic aluStep(input logic [2:0] op, input logic [2:0] sel, input logic [2:0] idx);
		logic [15:0] r;
		logic [3:0] f;
		tick();
		bus1Sel <= sel;
		regNum <= idx;
		aluOp <= op;
		regWrite <= 1'b1;
		regWdSrc <= 1'b1;
		aluRef(op, mT, (sel == bus1Const) ? 16'd2 : mRegs[idx], r, f);
		mRegs[idx] = r;
	endtask

	// only the constant 2 enters the datapath, so values are built by doubling
	task automatic buildValue(input logic [2:0] idx, input logic [15:0] v);
		loadTReg(idx);
		aluStep(opSub, bus1Reg, idx);
		for (int i = 15; i >= 1; i--) begin
			loadTReg(idx);
			aluStep(opAdd, bus1Reg, idx);
			if (v[i]) begin
				loadTReg(idx);
				aluStep(opAdd, bus1Const, idx);
			end
		end
	endtask

	task automatic readBack(input logic [2:0] idx);
		tick();
		bus1Sel <= bus1Reg;
		regNum <= idx;
		expectBus1(mRegs[idx]);
	endtask

	// a in r6, b in r7, result through ALUOut into r1, flags captured
	task automatic aluCase(input logic [2:0] op);
		logic [15:0] r;
		logic [3:0] f;
		buildValue(3'd6, rnd16() & 16'hFFFE);
		buildValue(3'd7, rnd16() & 16'hFFFE);
		loadTReg(3'd6);
		tick();
		bus1Sel <= bus1Reg;
		regNum <= 3'd7;
		aluOp <= op;
		flagWrite <= 1'b1;
		aluOutWrite <= 1'b1;
		aluRef(op, mT, mRegs[7], r, f);
		expectBus1(mRegs[7]);
		expectBus2(r);
		mFlags = f;
		tick();
		bus1Sel <= bus1AluOut;
		regNum <= 3'd1;
		regWrite <= 1'b1;
		regWdSrc <= 1'b0;
		chkFlags <= 1'b1;
		expFlags <= mFlags;
		mRegs[1] = r;
		readBack(3'd1);
	endtask

	// guards every clock wait of the main sequence
	initial begin
		for (int i = 0; i < maxCycles && !done; i++) begin
			@(posedge clk);
		end
		if (!done) begin
			$display("timeout: stimulus did not finish within %0d cycles", maxCycles);
			$display("tests failed");
			$finish;
		end
	end

	initial begin
		logic [2:0] idx;
		logic [1:0] sel;
		logic [15:0] addr;
		logic [15:0] data;
		logic sense;
		rstN = 1'b0;
		bus1Sel = bus1Pc;
		aluOp = opAdd;
		regNumSrc = regNumExt;
		regNum = 3'd0;
		jumpSel = 2'd0;
		{regWrite, regWdSrc, tWrite, irWrite, pcWrite, aluOutWrite} = '0;
		{marWrite, marSrc, mdrWrite, mdrSrc, memWrite, flagWrite, jumpEn} = '0;
		{chkPc, chkBus1, chkBus2, chkFlags} = '0;
		{expPc, expBus1, expBus2, expFlags} = '0;
		for (int i = 0; i < 8; i++) begin
			mRegs[i] = 16'd0;
		end
		mPc = 16'd0;
		mT = 16'd0;
		mFlags = 4'd0;
		for (int i = 0; i < 8; i++) begin
			tick();
		end
		rstN <= 1'b1;

		for (int i = 0; i < 8; i++) begin
			tick();
			bus1Sel <= bus1Reg;
			regNum <= 3'(i);
			expectBus1(16'd0);
			expectPc(16'd0);
			chkFlags <= 1'b1;
			expFlags <= 4'd0;
		end
		tick();
		chk.endTest("reset state");

		for (int i = 0; i < 12; i++) begin
			idx = 3'(rnd16());
			if (rnd16() < 16'h4000) begin
				tick();
				bus1Sel <= bus1Const;
				regNum <= idx;
				regWrite <= 1'b1;
				regWdSrc <= 1'b0;
				mRegs[idx] = 16'd2;
			end else begin
				buildValue(idx, rnd16() & 16'hFFFE);
			end
			readBack(idx);
		end
		tick();
		chk.endTest("register write and read");

		for (int op = 0; op <= 5; op++) begin
			for (int n = 0; n < 4; n++) begin
				aluCase(3'(op));
			end
		end
		tick();
		chk.endTest("alu and flags");

		for (int i = 0; i < 4; i++) begin
			tick();
			bus1Sel <= bus1Pc;
			tWrite <= 1'b1;
			mT = mPc;
			tick();
			bus1Sel <= bus1Const;
			aluOp <= opAdd;
			pcWrite <= 1'b1;
			expectBus2(mT + 16'd2);
			mPc = mT + 16'd2;
			tick();
			expectPc(mPc);
		end
		// sense bit comes from bit 7 of a built register value
		for (int i = 0; i < 10; i++) begin
			buildValue(3'd2, rnd16() & 16'hFFFE);
			tick();
			bus1Sel <= bus1Reg;
			regNum <= 3'd2;
			irWrite <= 1'b1;
			sense = mRegs[2][7];
			aluCase(3'(rnd16() % 16'd6));
			sel = 2'(rnd16());
			tick();
			bus1Sel <= bus1Const;
			aluOp <= opAdd;
			jumpEn <= 1'b1;
			jumpSel <= sel;
			expectBus2(mT + 16'd2);
			if (mFlags[sel] == sense) begin
				mPc = mT + 16'd2;
			end
			tick();
			expectPc(mPc);
		end
		tick();
		chk.endTest("pc step and jump");

		for (int i = 0; i < 8; i++) begin
			addr = rnd16() & 16'h00FE;
			data = rnd16() & 16'hFFFE;
			buildValue(3'd3, addr);
			tick();
			bus1Sel <= bus1Reg;
			regNum <= 3'd3;
			marWrite <= 1'b1;
			marSrc <= 1'b0;
			buildValue(3'd4, data);
			loadTReg(3'd4);
			// and with itself passes the word through to bus2
			tick();
			bus1Sel <= bus1Reg;
			regNum <= 3'd4;
			aluOp <= opAnd;
			mdrWrite <= 1'b1;
			mdrSrc <= 1'b0;
			expectBus2(data);
			tick();
			memWrite <= 1'b1;
			mMem[addr] = data;
			addrQ.push_back(addr);
		end
		foreach (addrQ[k]) begin
			buildValue(3'd3, addrQ[k]);
			tick();
			bus1Sel <= bus1Reg;
			regNum <= 3'd3;
			marWrite <= 1'b1;
			marSrc <= 1'b0;
			tick();
			mdrWrite <= 1'b1;
			mdrSrc <= 1'b1;
			tick();
			bus1Sel <= bus1Mdr;
			expectBus1(mMem[addrQ[k]]);
		end
		tick();
		chk.endTest("memory path");

		done = 1'b1;
		chk.summary();
		if (chk.errCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
hw/dpPkg.sv
hw/aluUnit.sv
hw/regBank.sv
hw/statusFlags.sv
hw/memBank.sv
hw/specialRegs.sv
hw/datapathTop.sv
bench/dpChecker.sv
bench/tbDatapath.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbDatapath
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx 'tests failed' $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif ! grep -qx 'all tests passed' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
